// File: src.f
common/eth_rx_pkg.sv
rtl/rx_term_locator.sv
rx_mac/slicing_crc.sv
rx_mac/rx_mac.sv
rtl/rx_frame_stats.sv
rtl/eth_rx_top.sv
sim/eth_rx_checker.sv
sim/eth_rx_monitor.sv
sim/eth_rx_tb.sv

// File: Makefile
# Verilator build and run of the eth_rx testbench
TOP := eth_rx_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f src.f

# Assertion errors are counted by the testbench, so the run must not stop at the first one
run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

// File: sim/eth_rx_tb.sv
/*
 Testbench for eth_rx_top. Seeded random frames with FCS flips, Error aborts and
 valid gaps. Expected beats and frame counts come from a bitwise CRC-32 model.
*/
`timescale 1ns/1ps
`default_nettype none

module eth_rx_tb;

    localparam logic [31:0] POLY    = 32'hEDB8_8320;
    localparam int          TIMEOUT = 200;

    logic                    clk;
    logic                    reset;
    eth_rx_pkg::xgmii_word_t xgmii;
    logic                    phy_valid;
    logic                    stats_req;
    eth_rx_pkg::axis_beat_t  axis;
    logic                    stats_ack;
    eth_rx_pkg::stats_t      stats;

    integer seed      = 49;
    int     exp_good  = 0;
    int     exp_bad   = 0;
    bit     timed_out = 1'b0;

    eth_rx_top #(
        .COUNT_WIDTH (16)
    ) i_dut (
        .i_clk          (clk),
        .i_reset        (reset),
        .i_xgmii        (xgmii),
        .i_phy_rx_valid (phy_valid),
        .o_axis         (axis),
        .i_stats_req    (stats_req),
        .o_stats_ack    (stats_ack),
        .o_stats        (stats)
    );

    eth_rx_monitor u_monitor (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_axis      (axis),
        .i_stats_req (stats_req),
        .i_stats_ack (stats_ack),
        .i_stats     (stats)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Reflected CRC-32, one byte shifted in LSB first
    function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'd0, b};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ POLY) : (c >> 1);
        end
        return c;
    endfunction

    task automatic drive_word(input logic [31:0] data, input logic [3:0] ctl);
        @(posedge clk);
        xgmii     <= '{data: data, ctl: ctl};
        phy_valid <= 1'b1;
    endtask

    // Valid low with junk on the bus, the locator has to hold its word
    task automatic drive_gap();
        @(posedge clk);
        xgmii     <= '{data: $random(seed), ctl: 4'($random(seed))};
        phy_valid <= 1'b0;
    endtask

    task automatic queue_beat(input logic [31:0] data, input logic [3:0] keep,
                              input logic last, input logic user);
        u_monitor.expect_beat('{tdata: data, tkeep: keep, tvalid: 1'b1,
                                tlast: last, tuser: user});
    endtask

    // kind 0 is clean, 1 flips one FCS bit, 2 aborts with an all-Error word
    task automatic send_frame(input int len, input int kind, input bit gaps);
        logic [7:0]  fb[$];
        logic [31:0] crc;
        logic [31:0] word;
        logic [3:0]  ctl;
        int          nfull;
        int          rem;
        int          abort_at;
        int          idx;
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < len; i++) begin
            fb.push_back(8'($random(seed)));
            crc = crc_update(crc, fb[i]);
        end
        crc = ~crc;
        // FCS goes out low byte first
        for (int i = 0; i < 4; i++) begin
            fb.push_back(crc[8*i +: 8]);
        end
        if (kind == 1) begin
            idx     = len + rand_below(4);
            fb[idx] = fb[idx] ^ 8'(1 << rand_below(8));
        end
        nfull    = fb.size() / 4;
        rem      = fb.size() % 4;
        abort_at = (kind == 2) ? rand_below(nfull) : -1;
        drive_word({8'h55, 8'h55, 8'h55, eth_rx_pkg::RS_START}, 4'b0001);
        drive_word({8'hD5, 8'h55, 8'h55, 8'h55}, 4'b0000);
        for (int w = 0; w < nfull; w++) begin
            if (gaps && rand_below(4) == 0) begin
                drive_gap();
            end
            if (w == abort_at) begin
                drive_word({4{eth_rx_pkg::RS_ERROR}}, 4'b1111);
                break;
            end
            word = {fb[4*w+3], fb[4*w+2], fb[4*w+1], fb[4*w]};
            drive_word(word, 4'b0000);
            queue_beat(word, 4'b1111, 1'b0, 1'b0);
        end
        if (kind != 2) begin
            // A gap right before Terminate makes the MAC use its held CRC
            if (gaps) begin
                drive_gap();
            end
            word = {4{eth_rx_pkg::RS_IDLE}};
            ctl  = 4'b1111;
            for (int i = 0; i < rem; i++) begin
                word[8*i +: 8] = fb[4*nfull + i];
                ctl[i]         = 1'b0;
            end
            word[8*rem +: 8] = eth_rx_pkg::RS_TERM;
            drive_word(word, ctl);
            queue_beat(word, 4'((1 << rem) - 1), 1'b1, kind == 0);
            if (kind == 0) begin
                exp_good++;
            end else begin
                exp_bad++;
            end
        end
        repeat (1 + rand_below(3)) begin
            drive_word({4{eth_rx_pkg::RS_IDLE}}, 4'b1111);
        end
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while (u_monitor.pending() != 0 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (u_monitor.pending() != 0) begin
            $display("Timeout: expected beats never came out during %s", what);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_frames(input string name, input int mode, input int count);
        int kind;
        if (timed_out) begin
            return;
        end
        for (int i = 0; i < count; i++) begin
            case (mode)
                0: send_frame(1 + rand_below(40), 0, 1'b0);
                1: send_frame(1 + rand_below(40), 1, 1'b0);
                // Lengths 1 to 8 put Terminate in every lane twice
                2: send_frame(1 + i, 0, 1'b0);
                3: begin
                    kind = (rand_below(4) == 0) ? 1 + rand_below(2) : 0;
                    send_frame(1 + rand_below(40), kind, 1'b1);
                end
                default: begin
                    send_frame(1 + rand_below(40), 2, 1'b0);
                    send_frame(1 + rand_below(40), 0, 1'b0);
                end
            endcase
        end
        wait_drain(name);
        if (!timed_out) begin
            u_monitor.end_test(name);
        end
    endtask

    task automatic read_stats(input string name);
        int n;
        if (timed_out) begin
            return;
        end
        u_monitor.expect_stats('{good_frames: 16'(exp_good), bad_frames: 16'(exp_bad)});
        @(posedge clk);
        stats_req <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!stats_ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!stats_ack) begin
            $display("Timeout: o_stats_ack never rose after the request");
            timed_out = 1'b1;
            return;
        end
        @(posedge clk);
        stats_req <= 1'b0;
        n = 0;
        @(negedge clk);
        while (stats_ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (stats_ack) begin
            $display("Timeout: o_stats_ack stayed high after the request dropped");
            timed_out = 1'b1;
            return;
        end
        u_monitor.end_test(name);
    endtask

    initial begin
        reset     = 1'b1;
        xgmii     = '{data: {4{eth_rx_pkg::RS_IDLE}}, ctl: 4'b1111};
        phy_valid = 1'b1;
        stats_req = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        run_frames("good_frames", 0, 10);
        run_frames("fcs_corrupt", 1, 8);
        run_frames("term_lanes", 2, 8);
        read_stats("stats_mid");
        run_frames("valid_gaps", 3, 24);
        run_frames("error_abort", 4, 6);
        read_stats("stats_end");
        u_monitor.final_report();
        if (timed_out || u_monitor.total_errors != 0 || i_dut.u_checker.fail_count != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/eth_rx_monitor.sv
/*
 Compares AXIS beats and stats reads against expectations queued by the testbench.
 Samples on the falling edge, when every DUT output has settled.
*/
`timescale 1ns/1ps
`default_nettype none

module eth_rx_monitor (
    input wire                         i_clk,
    input wire                         i_reset,
    input wire eth_rx_pkg::axis_beat_t i_axis,
    input wire                         i_stats_req,
    input wire                         i_stats_ack,
    input wire eth_rx_pkg::stats_t     i_stats
);

    eth_rx_pkg::axis_beat_t exp_q[$];
    eth_rx_pkg::stats_t     exp_stats;
    int   test_checks  = 0;
    int   test_errors  = 0;
    int   total_checks = 0;
    int   total_errors = 0;
    int   num_tests    = 0;
    int   cycle        = 0;
    int   req_rise_at  = 0;
    int   req_fall_at  = 0;
    logic req_q        = 1'b0;
    logic ack_q        = 1'b0;

    task automatic expect_beat(input eth_rx_pkg::axis_beat_t beat);
        exp_q.push_back(beat);
    endtask

    task automatic expect_stats(input eth_rx_pkg::stats_t counts);
        exp_stats = counts;
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        test_checks++;
        if (got !== want) begin
            test_errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, want);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-14s %0d checks, %0d errors", name, test_checks, test_errors);
        num_tests++;
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic final_report();
        total_checks += test_checks;
        total_errors += test_errors;
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 num_tests, total_checks, total_errors);
    endtask

    // Byte lanes outside tkeep carry Terminate or Idle and are not compared
    function automatic logic [31:0] lane_mask(input logic [3:0] keep);
        logic [31:0] m;
        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{keep[i]}};
        end
        return m;
    endfunction

    always @(negedge i_clk) begin : sample
        eth_rx_pkg::axis_beat_t want;
        cycle++;
        if (!i_reset) begin
            if (i_axis.tvalid) begin
                if (exp_q.size() == 0) begin
                    test_errors++;
                    $display("An AXIS beat came out when no beat was expected");
                end else begin
                    want = exp_q.pop_front();
                    check_value("o_axis.tkeep", 32'(i_axis.tkeep), 32'(want.tkeep));
                    check_value("o_axis.tdata", i_axis.tdata & lane_mask(want.tkeep),
                                want.tdata & lane_mask(want.tkeep));
                    check_value("o_axis.tlast", 32'(i_axis.tlast), 32'(want.tlast));
                    check_value("o_axis.tuser", 32'(i_axis.tuser), 32'(want.tuser));
                end
            end
            if (i_stats_req && !req_q) begin
                req_rise_at = cycle;
            end
            if (!i_stats_req && req_q) begin
                req_fall_at = cycle;
            end
            // Ack shows two samples after the request, one edge to see it and one to raise
            if (i_stats_ack && !ack_q) begin
                check_value("o_stats_ack rise delay", 32'(cycle - req_rise_at), 32'd2);
                check_value("o_stats.good_frames", 32'(i_stats.good_frames),
                            32'(exp_stats.good_frames));
                check_value("o_stats.bad_frames", 32'(i_stats.bad_frames),
                            32'(exp_stats.bad_frames));
            end
            if (!i_stats_ack && ack_q) begin
                check_value("o_stats_ack fall delay", 32'(cycle - req_fall_at), 32'd1);
            end
        end
        req_q = i_stats_req;
        ack_q = i_stats_ack;
    end

endmodule

`default_nettype wire

// File: sim/eth_rx_checker.sv
/*
 Protocol assertions bound into eth_rx_top, checked outside reset only.
 fail_count lets the testbench see assertion failures at the end of the run.
*/
`timescale 1ns/1ps
`default_nettype none

module eth_rx_checker (
    input wire                         i_clk,
    input wire                         i_reset,
    input wire eth_rx_pkg::axis_beat_t i_axis,
    input wire                         i_stats_req,
    input wire                         i_stats_ack,
    input wire eth_rx_pkg::stats_t     i_stats
);

    int fail_count = 0;

    // Side-band bits only mean something on a valid beat
    a_last_has_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_axis.tlast || i_axis.tuser) |-> i_axis.tvalid)
        else begin
            fail_count++;
            $error("tlast or tuser high without tvalid");
        end

    // A good-FCS flag can only sit on the closing beat
    a_user_has_last: assert property (@(posedge i_clk) disable iff (i_reset)
        i_axis.tuser |-> i_axis.tlast)
        else begin
            fail_count++;
            $error("tuser high without tlast");
        end

    // Snapshot must hold for as long as the acknowledge is up
    a_stats_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_stats_ack && $past(i_stats_ack)) |-> $stable(i_stats))
        else begin
            fail_count++;
            $error("o_stats changed while o_stats_ack was high");
        end

    // Four-phase rule, the acknowledge only drops once the request is gone
    a_ack_after_req: assert property (@(posedge i_clk) disable iff (i_reset)
        $fell(i_stats_ack) |-> !$past(i_stats_req))
        else begin
            fail_count++;
            $error("o_stats_ack fell while i_stats_req was still high");
        end

endmodule

bind eth_rx_top eth_rx_checker u_checker (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_axis      (o_axis),
    .i_stats_req (i_stats_req),
    .i_stats_ack (o_stats_ack),
    .i_stats     (o_stats)
);

`default_nettype wire

// File: rtl/eth_rx_top.sv
/*
 10G Ethernet receive path from raw XGMII words to AXIS beats and frame statistics.
 One register stage from XGMII to the beat. No back-pressure and a single clock.
*/
`timescale 1ns/1ps
`default_nettype none

module eth_rx_top #(
    parameter int COUNT_WIDTH = 16
) (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire eth_rx_pkg::xgmii_word_t i_xgmii,
    input  wire                          i_phy_rx_valid,
    output eth_rx_pkg::axis_beat_t       o_axis,
    input  wire                          i_stats_req,
    output logic                         o_stats_ack,
    output eth_rx_pkg::stats_t           o_stats
);

    // Locator to MAC, one registered word per cycle
    eth_rx_pkg::rx_word_t rx_word;

    rx_term_locator u_locator (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_xgmii        (i_xgmii),
        .i_phy_rx_valid (i_phy_rx_valid),
        .o_word         (rx_word)
    );

    rx_mac u_rx_mac (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_word  (rx_word),
        .o_axis  (o_axis)
    );

    // The statistics block watches the same beats that leave the top level
    rx_frame_stats #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_stats (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_axis      (o_axis),
        .i_stats_req (i_stats_req),
        .o_stats_ack (o_stats_ack),
        .o_stats     (o_stats)
    );

endmodule

`default_nettype wire

// File: rtl/rx_frame_stats.sv
/*
 Saturating good and bad frame counters with a four-phase req/ack snapshot read.
 A COUNT_WIDTH above the 16-bit stats_t fields is truncated in the snapshot.
 Holding the request high does not refresh the counts.
*/
`timescale 1ns/1ps
`default_nettype none

module rx_frame_stats #(
    parameter int COUNT_WIDTH = 16
) (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire eth_rx_pkg::axis_beat_t  i_axis,
    input  wire                          i_stats_req,
    output logic                         o_stats_ack,
    output eth_rx_pkg::stats_t           o_stats
);

    localparam int SNAP_WIDTH = $bits(eth_rx_pkg::stats_t) / 2;

    // Handshake phases, ack is decoded from HS_ACK alone
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_LATCH,
        HS_ACK
    } hs_state_t;

    hs_state_t              hs_q;
    logic [COUNT_WIDTH-1:0] good_cnt_q;
    logic [COUNT_WIDTH-1:0] bad_cnt_q;
    logic                   frame_done;

    // No ready, so a last beat counts as soon as it is valid
    assign frame_done = i_axis.tvalid && i_axis.tlast;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            good_cnt_q <= '0;
            bad_cnt_q  <= '0;
        end else if (frame_done) begin
            // Both counters stick at all ones instead of wrapping
            if (i_axis.tuser) begin
                if (good_cnt_q != '1) begin
                    good_cnt_q <= good_cnt_q + 1'b1;
                end
            end else begin
                if (bad_cnt_q != '1) begin
                    bad_cnt_q <= bad_cnt_q + 1'b1;
                end
            end
        end
    end

    // Request seen in HS_IDLE latches the counts, ack follows one edge later
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            hs_q <= HS_IDLE;
        end else begin
            case (hs_q)
                HS_IDLE: begin
                    if (i_stats_req) begin
                        hs_q <= HS_LATCH;
                    end
                end
                HS_LATCH: begin
                    hs_q <= HS_ACK;
                end
                HS_ACK: begin
                    // Ack drops on the first edge that sees the request low
                    if (!i_stats_req) begin
                        hs_q <= HS_IDLE;
                    end
                end
                default: begin
                    hs_q <= HS_IDLE;
                end
            endcase
        end
    end

    // The snapshot only changes in HS_IDLE, so it is stable while ack is high
    always_ff @(posedge i_clk) begin
        if ((hs_q == HS_IDLE) && i_stats_req) begin
            o_stats <= '{good_frames: SNAP_WIDTH'(good_cnt_q),
                         bad_frames:  SNAP_WIDTH'(bad_cnt_q)};
        end
    end

    assign o_stats_ack = (hs_q == HS_ACK);

endmodule

`default_nettype wire

// File: rx_mac/rx_mac.sv
/*
 10G receive MAC over 32-bit XGMII words with Terminate location supplied by the PCS.
 The data path is combinational, the start word and the SFD word make no beat.
 FCS bytes are passed through, tuser with tlast reports a matching CRC.
 No back-pressure, the PHY valid paces every beat.
*/
`timescale 1ns/1ps
`default_nettype none

module rx_mac (
    input  wire                       i_clk,
    input  wire                       i_reset,
    input  wire eth_rx_pkg::rx_word_t i_word,
    output eth_rx_pkg::axis_beat_t    o_axis
);

    eth_rx_pkg::rx_state_t state_q;
    eth_rx_pkg::rx_state_t state_d;

    // Fields of the incoming word
    logic [eth_rx_pkg::DATA_WIDTH-1:0]  rx_data;
    logic [eth_rx_pkg::DATA_NBYTES-1:0] rx_ctl;
    logic                               rx_valid;
    logic [eth_rx_pkg::DATA_NBYTES-1:0] term_loc;

    // Frame delimiting
    logic                               start_found;
    logic                               sfd_del_q;
    logic                               ctl_found;
    logic                               err_found;
    logic                               term_found;
    logic [eth_rx_pkg::DATA_NBYTES-1:0] term_keep;

    // Beat forming
    logic                               beat_valid;
    logic                               frame_end;
    logic [eth_rx_pkg::DATA_NBYTES-1:0] beat_keep;

    // CRC feed, one beat behind the output
    logic [eth_rx_pkg::DATA_WIDTH-1:0]  data_del_q;
    logic [eth_rx_pkg::DATA_NBYTES-1:0] keep_del_q;
    logic [eth_rx_pkg::DATA_NBYTES-1:0] crc_en;
    logic                               crc_reset;
    logic [31:0]                        crc_calc;
    logic [31:0]                        fcs_rx;
    logic                               crc_good;

    assign rx_data  = i_word.xgmii.data;
    assign rx_ctl   = i_word.xgmii.ctl;
    assign rx_valid = i_word.valid;
    assign term_loc = i_word.term_loc;

    // Start is only recognised in lane 0 and only between frames
    assign start_found = rx_valid && (state_q == eth_rx_pkg::IDLE) && rx_ctl[0] &&
                         (rx_data[7:0] == eth_rx_pkg::RS_START);

    assign ctl_found  = |rx_ctl;
    assign term_found = rx_valid && (|term_loc);

    always_comb begin
        err_found = 1'b0;
        for (int i = 0; i < eth_rx_pkg::DATA_NBYTES; i++) begin
            if (rx_ctl[i] && (rx_data[8*i +: 8] == eth_rx_pkg::RS_ERROR)) begin
                err_found = 1'b1;
            end
        end
    end

    // Keep the lanes below the first Terminate, so lane 0 gives an empty keep
    always_comb begin : term_keep_comb
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < eth_rx_pkg::DATA_NBYTES; i++) begin
            term_keep[i] = !seen && !term_loc[i];
            seen         = seen | term_loc[i];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= eth_rx_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Any control character in a valid word closes the frame, Error included
    always_comb begin
        state_d = state_q;
        case (state_q)
            eth_rx_pkg::IDLE: begin
                if (start_found) begin
                    state_d = eth_rx_pkg::DATA;
                end
            end
            eth_rx_pkg::DATA: begin
                if (rx_valid && ctl_found) begin
                    state_d = eth_rx_pkg::IDLE;
                end
            end
            default: begin
                state_d = eth_rx_pkg::IDLE;
            end
        endcase
    end

    // The word after Start is all preamble and SFD, this flag hides it
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            sfd_del_q <= 1'b0;
        end else if (rx_valid) begin
            sfd_del_q <= start_found;
        end
    end

    // An Error word makes no beat, so an aborted frame never shows tlast
    assign beat_valid = (state_q == eth_rx_pkg::DATA) && rx_valid && !err_found && !sfd_del_q;
    assign frame_end  = beat_valid && ctl_found;

    always_comb begin
        if (!beat_valid) begin
            beat_keep = '0;
        end else if (term_found) begin
            beat_keep = term_keep;
        end else begin
            beat_keep = '1;
        end
    end

    always_comb begin
        o_axis.tdata  = rx_data;
        o_axis.tkeep  = beat_keep;
        o_axis.tvalid = beat_valid;
        o_axis.tlast  = frame_end;
        o_axis.tuser  = frame_end && term_found && crc_good;
    end

    // Previous valid word, fed to the CRC once the next word shows where the FCS sits
    always_ff @(posedge i_clk) begin
        if (rx_valid) begin
            data_del_q <= rx_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            keep_del_q <= '0;
        end else if (rx_valid) begin
            keep_del_q <= beat_keep;
        end
    end

    // With Terminate in lane k the delayed lanes from k up are FCS
    // Valid-low cycles hold the CRC, so after a gap the held state still fits
    always_comb begin
        if (!rx_valid) begin
            crc_en = '0;
        end else if (term_found) begin
            crc_en = keep_del_q & term_keep;
        end else begin
            crc_en = keep_del_q;
        end
    end

    // Received FCS straddles the delayed and current words
    always_comb begin
        case (term_loc)
            4'b0001: fcs_rx = data_del_q;
            4'b0010: fcs_rx = {rx_data[7:0], data_del_q[31:8]};
            4'b0100: fcs_rx = {rx_data[15:0], data_del_q[31:16]};
            4'b1000: fcs_rx = {rx_data[23:0], data_del_q[31:24]};
            default: fcs_rx = rx_data;
        endcase
    end

    assign crc_reset = i_reset || (state_q == eth_rx_pkg::IDLE);
    assign crc_good  = (crc_calc == fcs_rx);

    slicing_crc u_rx_crc (
        .i_clk   (i_clk),
        .i_reset (crc_reset),
        .i_data  (data_del_q),
        .i_valid (crc_en),
        .o_crc   (crc_calc)
    );

endmodule

`default_nettype wire

// File: rx_mac/slicing_crc.sv
/*
 Reflected CRC-32 (IEEE 802.3) over up to four bytes per cycle.
 o_crc already includes the bytes enabled this cycle and is inverted.
 Synchronous reset loads the all-ones seed.
*/
`timescale 1ns/1ps
`default_nettype none

module slicing_crc (
    input  wire                                      i_clk,
    input  wire                                      i_reset,
    input  wire [eth_rx_pkg::DATA_WIDTH-1:0]         i_data,
    input  wire [eth_rx_pkg::DATA_NBYTES-1:0]        i_valid,
    output logic [31:0]                              o_crc
);

    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
    // Bit-reversed form of 0x04C11DB7
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // Byte 0 goes in first, each byte is shifted LSB first
    // Disabled lanes are skipped, the MAC only enables low-order lanes
    always_comb begin
        crc_next = crc_q;
        for (int b = 0; b < eth_rx_pkg::DATA_NBYTES; b++) begin
            if (i_valid[b]) begin
                crc_next[7:0] = crc_next[7:0] ^ i_data[8*b +: 8];
                for (int k = 0; k < 8; k++) begin
                    if (crc_next[0]) begin
                        crc_next = (crc_next >> 1) ^ CRC_POLY;
                    end else begin
                        crc_next = crc_next >> 1;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            crc_q <= CRC_INIT;
        end else begin
            crc_q <= crc_next;
        end
    end

    // Result is ready in the same cycle as the last enabled byte
    assign o_crc = ~crc_next;

endmodule

`default_nettype wire

// File: rtl/rx_term_locator.sv
/*
 PCS-side register stage. Flags the lanes carrying Terminate ahead of the MAC.
 Data and Terminate location are held while the PHY valid is low.
*/
`timescale 1ns/1ps
`default_nettype none

module rx_term_locator (
    input  wire                       i_clk,
    input  wire                       i_reset,
    input  wire eth_rx_pkg::xgmii_word_t i_xgmii,
    input  wire                       i_phy_rx_valid,
    output eth_rx_pkg::rx_word_t      o_word
);

    logic [eth_rx_pkg::DATA_NBYTES-1:0] term_loc;
    eth_rx_pkg::xgmii_word_t            xgmii_q;
    logic                               valid_q;
    logic [eth_rx_pkg::DATA_NBYTES-1:0] term_loc_q;

    // One comparator per lane, a lane only counts when its control flag is set
    always_comb begin
        for (int i = 0; i < eth_rx_pkg::DATA_NBYTES; i++) begin
            term_loc[i] = i_xgmii.ctl[i] &&
                          (i_xgmii.data[8*i +: 8] == eth_rx_pkg::RS_TERM);
        end
    end

    // Word payload is only captured on valid cycles
    always_ff @(posedge i_clk) begin
        if (i_phy_rx_valid) begin
            xgmii_q <= i_xgmii;
        end
    end

    // Valid follows the PHY every cycle, the lane flags are held with the data
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            valid_q    <= 1'b0;
            term_loc_q <= '0;
        end else begin
            valid_q <= i_phy_rx_valid;
            if (i_phy_rx_valid) begin
                term_loc_q <= term_loc;
            end
        end
    end

    assign o_word.xgmii    = xgmii_q;
    assign o_word.valid    = valid_q;
    assign o_word.term_loc = term_loc_q;

endmodule

`default_nettype wire

// File: common/eth_rx_pkg.sv
/*
 Shared XGMII codes, beat structs and state types for the 10G receive path.
 The word geometry is fixed at 32 bits. stats_t follows the default 16-bit count width.
*/
`default_nettype none

package eth_rx_pkg;

    // XGMII control characters as they appear on a lane with its control flag set
    localparam logic [7:0] RS_IDLE  = 8'h07;
    localparam logic [7:0] RS_START = 8'hFB;
    localparam logic [7:0] RS_TERM  = 8'hFD;
    localparam logic [7:0] RS_ERROR = 8'hFE;

    // Word geometry, not a parameter since start handling relies on 32 bits
    localparam int DATA_WIDTH  = 32;
    localparam int DATA_NBYTES = DATA_WIDTH / 8;

    // One raw XGMII word, lane 0 in the low byte
    typedef struct packed {
        logic [DATA_WIDTH-1:0]  data;
        logic [DATA_NBYTES-1:0] ctl;
    } xgmii_word_t;

    // Registered word from the locator, with the one-hot Terminate lane
    typedef struct packed {
        xgmii_word_t            xgmii;
        logic                   valid;
        logic [DATA_NBYTES-1:0] term_loc;
    } rx_word_t;

    // AXI-Stream style beat without tready
    // tuser set with tlast marks a frame whose FCS matched
    typedef struct packed {
        logic [DATA_WIDTH-1:0]  tdata;
        logic [DATA_NBYTES-1:0] tkeep;
        logic                   tvalid;
        logic                   tlast;
        logic                   tuser;
    } axis_beat_t;

    // Receive MAC frame state
    typedef enum logic {
        IDLE,
        DATA
    } rx_state_t;

    // Snapshot of the frame counters
    // The fields are 16 bits to match the default COUNT_WIDTH of the top level
    typedef struct packed {
        logic [15:0] good_frames;
        logic [15:0] bad_frames;
    } stats_t;

endpackage

`default_nettype wire
